// ==== hdl/dispatch_defs.svh ====
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// core counts on each side
`define NUM_RT 4
`define NUM_IC 4

// threads per patch
`define NUM_THREAD 32

// thread id width, enough for NUM_THREAD ids
`define TID_W 5

// pixel id, pc and sp all share this width
`define WORD_W 32

// initial sp carries its tid from this bit up
`define SP_TID_LSB 16

`endif

// ==== hdl/dispatch_pkg.sv ====
`include "dispatch_defs.svh"

package dispatch_pkg;

    typedef logic [`TID_W-1:0] tid_t;
    typedef logic [`WORD_W-1:0] word_t;

    // context handed over by an RT on a switch
    typedef struct packed {
        tid_t  tid;
        word_t pc;
        word_t sp;
    } rt_switch_t;

    // one beat from the command processor
    typedef struct packed {
        logic  valid;
        word_t pixel_id;
    } cp_load_t;

    // save of a switched thread into the context tables
    typedef struct packed {
        logic  valid;
        tid_t  tid;
        word_t pc;
        word_t sp;
    } ctx_write_t;

    typedef struct packed {
        tid_t  tid;
        word_t pixel_id;
        word_t pc;
        word_t sp;
    } rt_job_t;

endpackage

// ==== hdl/thread_fifo.sv ====
`timescale 1ns/10ps
`include "dispatch_defs.svh"

module thread_fifo import dispatch_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  tid_t push_tid,
    input  logic pop,
    output logic empty,
    output tid_t head_tid
);

    localparam int CNT_W = `TID_W + 1;

    tid_t mem [`NUM_THREAD];
    tid_t wr_ptr;
    tid_t rd_ptr;
    logic [CNT_W-1:0] count;
    logic full;

    function automatic tid_t next_ptr(input tid_t ptr);
        return (ptr == tid_t'(`NUM_THREAD - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == CNT_W'(`NUM_THREAD));
    // show-ahead, head valid whenever not empty
    assign head_tid = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_tid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one slot per thread, so a full queue means a duplicated thread
    assert property (@(posedge clk) disable iff (!rst_n) !(push && full && !pop));
    assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

// ==== hdl/switch_arbiter.sv ====
`timescale 1ns/10ps

module switch_arbiter #(
    parameter int NUM_CORES = 4,
    parameter type payload_t = logic
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_CORES-1:0] req,
    input  payload_t             req_data [NUM_CORES],
    input  logic                 stall,
    output logic [NUM_CORES-1:0] grant,
    output payload_t             grant_data
);

    logic [NUM_CORES-1:0] pending;
    logic [NUM_CORES-1:0] active;
    payload_t held [NUM_CORES];
    payload_t cur [NUM_CORES];

    // a fresh pulse competes in its own cycle
    assign active = pending | req;

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            cur[i] = pending[i] ? held[i] : req_data[i];
        end
    end

    // lowest set bit wins
    assign grant = stall ? '0 : active & (~active + 1'b1);

    always_comb begin
        grant_data = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            if (grant[i]) begin
                grant_data = cur[i];
            end
        end
    end

    // payload captured on the pulse, kept until granted
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CORES; i++) begin
            if (req[i] && !pending[i]) begin
                held[i] <= req_data[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= active & ~grant;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant));
    // a core waits for its grant before it switches again
    assert property (@(posedge clk) disable iff (!rst_n) (req & pending) == '0);

endmodule

// ==== hdl/ic_dispatch.sv ====
`timescale 1ns/10ps
`include "dispatch_defs.svh"

module ic_dispatch import dispatch_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`NUM_RT-1:0] context_switch_rt,
    input  rt_switch_t         rt_switch [`NUM_RT],
    output logic [`NUM_RT-1:0] rt_freed,
    output ctx_write_t         ctx_save,
    output logic [`NUM_IC-1:0] job_dispatch_ic,
    output tid_t               thread_id_ic,
    input  logic [`NUM_IC-1:0] context_switch_ic,
    input  logic [`NUM_IC-1:0] ic_freed
);

    logic [`NUM_RT-1:0] rt_grant;
    rt_switch_t granted;
    logic q_empty;
    logic [`NUM_IC-1:0] ic_busy;
    logic [`NUM_IC-1:0] ic_idle;

    switch_arbiter #(
        .NUM_CORES (`NUM_RT),
        .payload_t (rt_switch_t)
    ) u_rt_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (context_switch_rt),
        .req_data   (rt_switch),
        .stall      (1'b0),
        .grant      (rt_grant),
        .grant_data (granted)
    );

    // granted RT gives up its thread, pc and sp go to the tables
    assign rt_freed = rt_grant;
    assign ctx_save = '{valid: |rt_grant, tid: granted.tid, pc: granted.pc, sp: granted.sp};

    thread_fifo u_rt2ic_q (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (|rt_grant),
        .push_tid (granted.tid),
        .pop      (|job_dispatch_ic),
        .empty    (q_empty),
        .head_tid (thread_id_ic)
    );

    // lowest idle IC takes the head
    assign ic_idle = ~ic_busy;
    assign job_dispatch_ic = q_empty ? '0 : ic_idle & (~ic_idle + 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ic_busy <= '0;
        end else begin
            ic_busy <= (ic_busy & ~ic_freed) | job_dispatch_ic;
        end
    end

    // an IC only switches out a thread it was given
    assert property (@(posedge clk) disable iff (!rst_n)
        (context_switch_ic & ~ic_busy) == '0);

endmodule

// ==== hdl/rt_dispatch.sv ====
`timescale 1ns/10ps
`include "dispatch_defs.svh"

module rt_dispatch import dispatch_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`NUM_IC-1:0] context_switch_ic,
    input  tid_t               ic_switch_tid [`NUM_IC],
    output logic [`NUM_IC-1:0] ic_freed,
    input  logic               load_active,
    input  tid_t               load_tid,
    input  logic [`NUM_RT-1:0] task_done_rt,
    input  logic [`NUM_RT-1:0] rt_freed,
    output logic               rt_take,
    output tid_t               rt_take_tid,
    output logic [`NUM_RT-1:0] job_dispatch_rt
);

    logic [`NUM_IC-1:0] ic_grant;
    tid_t ic_tid;
    logic q_push;
    tid_t q_push_tid;
    logic q_empty;
    logic [`NUM_RT-1:0] rt_busy;
    logic [`NUM_RT-1:0] rt_idle;
    logic [`NUM_RT-1:0] rt_sel;

    // load owns the queue input, IC switches wait meanwhile
    switch_arbiter #(
        .NUM_CORES (`NUM_IC),
        .payload_t (tid_t)
    ) u_ic_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (context_switch_ic),
        .req_data   (ic_switch_tid),
        .stall      (load_active),
        .grant      (ic_grant),
        .grant_data (ic_tid)
    );

    assign ic_freed = ic_grant;
    assign q_push = load_active | (|ic_grant);
    assign q_push_tid = load_active ? load_tid : ic_tid;

    thread_fifo u_ic2rt_q (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (q_push),
        .push_tid (q_push_tid),
        .pop      (rt_take),
        .empty    (q_empty),
        .head_tid (rt_take_tid)
    );

    // no selection during a load beat
    assign rt_idle = ~rt_busy;
    assign rt_sel = (load_active || q_empty) ? '0 : rt_idle & (~rt_idle + 1'b1);
    assign rt_take = |rt_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_busy <= '0;
            job_dispatch_rt <= '0;
        end else begin
            rt_busy <= (rt_busy & ~(task_done_rt | rt_freed)) | rt_sel;
            // pulse lines up with the registered rt_job
            job_dispatch_rt <= rt_sel;
        end
    end

endmodule

// ==== hdl/thread_context.sv ====
`timescale 1ns/10ps
`include "dispatch_defs.svh"

module thread_context import dispatch_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  cp_load_t           load,
    input  ctx_write_t         ctx_save,
    input  logic               rt_take,
    input  tid_t               rt_take_tid,
    input  logic [`NUM_RT-1:0] task_done_rt,
    output logic               load_active,
    output tid_t               load_tid,
    output rt_job_t            rt_job,
    output logic               patch_done
);

    localparam int CNT_W = `TID_W + 1;

    word_t pixel_tbl [`NUM_THREAD];
    word_t pc_tbl [`NUM_THREAD];
    word_t sp_tbl [`NUM_THREAD];
    logic [CNT_W-1:0] load_count;
    logic [CNT_W-1:0] done_count;
    logic [CNT_W-1:0] done_now;
    logic first_beat;

    // top bit set, tid in the upper half
    function automatic word_t init_sp(input tid_t tid);
        word_t sp;
        sp = '0;
        sp[`WORD_W-1] = 1'b1;
        sp[`SP_TID_LSB +: `TID_W] = tid;
        return sp;
    endfunction

    // tid is the load position within the patch
    assign load_active = load.valid;
    assign load_tid = load_count[`TID_W-1:0];
    assign first_beat = load.valid && (load_count == '0);
    assign patch_done = (load_count != '0) && (done_count == load_count);

    always_comb begin
        done_now = '0;
        for (int i = 0; i < `NUM_RT; i++) begin
            done_now = done_now + CNT_W'(task_done_rt[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_count <= '0;
            done_count <= '0;
        end else if (patch_done) begin
            load_count <= '0;
            done_count <= '0;
        end else begin
            if (load.valid) begin
                load_count <= load_count + 1'b1;
            end
            done_count <= done_count + done_now;
        end
    end

    always_ff @(posedge clk) begin
        if (load.valid) begin
            pixel_tbl[load_tid] <= load.pixel_id;
        end
    end

    // new patch starts every thread from pc 0 and its own stack
    always_ff @(posedge clk) begin
        if (first_beat) begin
            for (int i = 0; i < `NUM_THREAD; i++) begin
                pc_tbl[i] <= '0;
                sp_tbl[i] <= init_sp(tid_t'(i));
            end
        end else if (ctx_save.valid) begin
            pc_tbl[ctx_save.tid] <= ctx_save.pc;
            sp_tbl[ctx_save.tid] <= ctx_save.sp;
        end
    end

    always_ff @(posedge clk) begin
        if (rt_take) begin
            rt_job.tid <= rt_take_tid;
            rt_job.pixel_id <= pixel_tbl[rt_take_tid];
            rt_job.pc <= pc_tbl[rt_take_tid];
            rt_job.sp <= sp_tbl[rt_take_tid];
        end
    end

    // each loaded thread completes once per patch
    assert property (@(posedge clk) disable iff (!rst_n) done_count <= load_count);

endmodule

// ==== hdl/patch_dispatcher.sv ====
`timescale 1ns/10ps
`include "dispatch_defs.svh"

module patch_dispatcher import dispatch_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  cp_load_t           load,
    input  logic [`NUM_RT-1:0] task_done_rt,
    input  logic [`NUM_RT-1:0] context_switch_rt,
    input  rt_switch_t         rt_switch [`NUM_RT],
    input  logic [`NUM_IC-1:0] context_switch_ic,
    input  tid_t               ic_switch_tid [`NUM_IC],
    output logic [`NUM_RT-1:0] job_dispatch_rt,
    output rt_job_t            rt_job,
    output logic [`NUM_IC-1:0] job_dispatch_ic,
    output tid_t               thread_id_ic,
    output logic               patch_done
);

    logic [`NUM_RT-1:0] rt_freed;
    logic [`NUM_IC-1:0] ic_freed;
    ctx_write_t ctx_save;
    logic rt_take;
    tid_t rt_take_tid;
    logic load_active;
    tid_t load_tid;

    // RT to IC
    ic_dispatch u_ic_dispatch (
        .clk               (clk),
        .rst_n             (rst_n),
        .context_switch_rt (context_switch_rt),
        .rt_switch         (rt_switch),
        .rt_freed          (rt_freed),
        .ctx_save          (ctx_save),
        .job_dispatch_ic   (job_dispatch_ic),
        .thread_id_ic      (thread_id_ic),
        .context_switch_ic (context_switch_ic),
        .ic_freed          (ic_freed)
    );

    // IC to RT, also the entry point of loaded threads
    rt_dispatch u_rt_dispatch (
        .clk               (clk),
        .rst_n             (rst_n),
        .context_switch_ic (context_switch_ic),
        .ic_switch_tid     (ic_switch_tid),
        .ic_freed          (ic_freed),
        .load_active       (load_active),
        .load_tid          (load_tid),
        .task_done_rt      (task_done_rt),
        .rt_freed          (rt_freed),
        .rt_take           (rt_take),
        .rt_take_tid       (rt_take_tid),
        .job_dispatch_rt   (job_dispatch_rt)
    );

    thread_context u_thread_context (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .ctx_save     (ctx_save),
        .rt_take      (rt_take),
        .rt_take_tid  (rt_take_tid),
        .task_done_rt (task_done_rt),
        .load_active  (load_active),
        .load_tid     (load_tid),
        .rt_job       (rt_job),
        .patch_done   (patch_done)
    );

endmodule

// ==== tb/patch_dispatcher_tb.sv ====
`timescale 1ns/10ps
`include "dispatch_defs.svh"

module patch_dispatcher_tb import dispatch_pkg::*; ();

    // two patches of 8 and 4 threads
    localparam int NUM_LOADED = 12;
    localparam int TIMEOUT_CYCLES = 40 * NUM_LOADED + 200;

    logic clk;
    logic rst_n;
    cp_load_t load;
    logic [`NUM_RT-1:0] task_done_rt;
    logic [`NUM_RT-1:0] context_switch_rt;
    rt_switch_t rt_switch [`NUM_RT];
    logic [`NUM_IC-1:0] context_switch_ic;
    tid_t ic_switch_tid [`NUM_IC];
    logic [`NUM_RT-1:0] job_dispatch_rt;
    rt_job_t rt_job;
    logic [`NUM_IC-1:0] job_dispatch_ic;
    tid_t thread_id_ic;
    logic patch_done;

    // core models
    logic [`NUM_RT-1:0] rt_busy_m;
    logic [`NUM_IC-1:0] ic_busy_m;
    tid_t rt_thread [`NUM_RT];
    tid_t ic_thread [`NUM_IC];
    // thread order each queue should deliver
    tid_t rt_expect [$];
    tid_t ic_expect [$];
    word_t pix_m [`NUM_THREAD];
    word_t pc_m [`NUM_THREAD];
    word_t sp_m [`NUM_THREAD];
    int loaded_m;
    int done_m;
    int rt_jobs;
    int ic_jobs;
    int patch_count;
    int checks;
    int errors;
    int cycles;
    string test_name;
    logic [15:0] lfsr;
    logic [31:0] pick;

    patch_dispatcher UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .load              (load),
        .task_done_rt      (task_done_rt),
        .context_switch_rt (context_switch_rt),
        .rt_switch         (rt_switch),
        .context_switch_ic (context_switch_ic),
        .ic_switch_tid     (ic_switch_tid),
        .job_dispatch_rt   (job_dispatch_rt),
        .rt_job            (rt_job),
        .job_dispatch_ic   (job_dispatch_ic),
        .thread_id_ic      (thread_id_ic),
        .patch_done        (patch_done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // msb set, tid at SP_TID_LSB, zeros elsewhere
    function automatic word_t initial_sp(input tid_t tid);
        return {1'b1, {(`WORD_W - 1 - `SP_TID_LSB - `TID_W){1'b0}}, tid, {`SP_TID_LSB{1'b0}}};
    endfunction

    function automatic rt_job_t expected_job(input tid_t tid);
        rt_job_t job;
        job.tid = tid;
        job.pixel_id = pix_m[tid];
        job.pc = pc_m[tid];
        job.sp = sp_m[tid];
        return job;
    endfunction

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h",
                     test_name, label, expected, actual);
        end
    endtask

    // pulses last one cycle and are cleared here
    task automatic next_cycle();
        @(posedge clk);
        #1;
        load = '0;
        task_done_rt = '0;
        context_switch_rt = '0;
        context_switch_ic = '0;
    endtask

    task automatic load_patch(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            take_bits(32, pick);
            if (i == 0) begin
                for (int t = 0; t < `NUM_THREAD; t++) begin
                    pc_m[t] = '0;
                    sp_m[t] = initial_sp(tid_t'(t));
                end
            end
            load = '{valid: 1'b1, pixel_id: pick};
            pix_m[i] = pick;
            rt_expect.push_back(tid_t'(i));
            loaded_m++;
        end
    endtask

    task automatic switch_rt(input int core);
        word_t pc;
        word_t sp;
        tid_t tid;
        take_bits(32, pc);
        take_bits(32, sp);
        tid = rt_thread[core];
        context_switch_rt[core] = 1'b1;
        rt_switch[core] = '{tid: tid, pc: pc, sp: sp};
        pc_m[tid] = pc;
        sp_m[tid] = sp;
        rt_busy_m[core] = 1'b0;
        ic_expect.push_back(tid);
    endtask

    task automatic switch_ic(input int core);
        context_switch_ic[core] = 1'b1;
        ic_switch_tid[core] = ic_thread[core];
        ic_busy_m[core] = 1'b0;
        rt_expect.push_back(ic_thread[core]);
    endtask

    task automatic complete_rt(input int core);
        task_done_rt[core] = 1'b1;
        rt_busy_m[core] = 1'b0;
        done_m++;
    endtask

    task automatic wait_rt_jobs(input int target);
        next_cycle();
        while (rt_jobs < target) next_cycle();
    endtask

    task automatic wait_ic_jobs(input int target);
        next_cycle();
        while (ic_jobs < target) next_cycle();
    endtask

    // return IC threads, then retire every thread on random RTs
    task automatic finish_patch();
        int target;
        target = patch_count + 1;
        next_cycle();
        for (int i = 0; i < `NUM_IC; i++) begin
            if (ic_busy_m[i]) switch_ic(i);
        end
        while (done_m < loaded_m) begin
            next_cycle();
            take_bits(2, pick);
            if (rt_busy_m[pick[1:0]]) complete_rt(pick[1:0]);
        end
        next_cycle();
        while (patch_count < target) next_cycle();
        repeat (5) next_cycle();
        check_value("patch done pulses", target, patch_count);
        loaded_m = 0;
        done_m = 0;
    endtask

    always @(negedge clk) begin
        int core;
        tid_t tid;
        rt_job_t exp;
        if (rst_n && job_dispatch_rt != '0) begin
            core = 0;
            for (int i = 0; i < `NUM_RT; i++) begin
                if (job_dispatch_rt[i]) core = i;
            end
            check_value("rt one-hot", 1, $countones(job_dispatch_rt));
            check_value("rt idle before job", 0, rt_busy_m[core]);
            if (rt_expect.size() == 0) begin
                errors++;
                $display("RT %0d received a job while no thread was waiting", core);
            end else begin
                tid = rt_expect.pop_front();
                exp = expected_job(tid);
                check_value("rt tid", exp.tid, rt_job.tid);
                check_value("rt pixel_id", exp.pixel_id, rt_job.pixel_id);
                check_value("rt pc", exp.pc, rt_job.pc);
                check_value("rt sp", exp.sp, rt_job.sp);
            end
            rt_busy_m[core] = 1'b1;
            rt_thread[core] = rt_job.tid;
            rt_jobs++;
        end
        if (rst_n && job_dispatch_ic != '0) begin
            core = 0;
            for (int i = 0; i < `NUM_IC; i++) begin
                if (job_dispatch_ic[i]) core = i;
            end
            check_value("ic one-hot", 1, $countones(job_dispatch_ic));
            check_value("ic idle before job", 0, ic_busy_m[core]);
            if (ic_expect.size() == 0) begin
                errors++;
                $display("IC %0d received a job while no thread was waiting", core);
            end else begin
                check_value("ic tid", ic_expect.pop_front(), thread_id_ic);
            end
            ic_busy_m[core] = 1'b1;
            ic_thread[core] = thread_id_ic;
            ic_jobs++;
        end
        if (rst_n && patch_done) patch_count++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, checks: %0d, errors: %0d",
                     cycles, checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        load = '0;
        task_done_rt = '0;
        context_switch_rt = '0;
        context_switch_ic = '0;
        for (int i = 0; i < `NUM_RT; i++) rt_switch[i] = '0;
        for (int i = 0; i < `NUM_IC; i++) ic_switch_tid[i] = '0;
        rt_busy_m = '0;
        ic_busy_m = '0;
        lfsr = 16'd22;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        test_name = "load";
        load_patch(8);
        wait_rt_jobs(4);
        for (int i = 0; i < `NUM_RT; i++) check_value("rt thread", i, rt_thread[i]);

        test_name = "rt switch";
        next_cycle();
        switch_rt(2);
        wait_ic_jobs(1);
        wait_rt_jobs(5);
        check_value("ic0 thread", 2, ic_thread[0]);
        check_value("rt2 thread", 4, rt_thread[2]);

        // thread 2 queues behind 5..7 and reaches RT 0 after four completions
        test_name = "ic switch";
        next_cycle();
        switch_ic(0);
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            complete_rt(0);
            wait_rt_jobs(rt_jobs + 1);
        end
        check_value("rt0 thread", 2, rt_thread[0]);

        test_name = "dual rt switch";
        next_cycle();
        switch_rt(1);
        switch_rt(3);
        wait_ic_jobs(ic_jobs + 2);
        check_value("ic0 thread", 1, ic_thread[0]);
        check_value("ic1 thread", 3, ic_thread[1]);

        test_name = "completion";
        finish_patch();
        test_name = "second load";
        load_patch(4);
        wait_rt_jobs(rt_jobs + 4);
        for (int i = 0; i < `NUM_RT; i++) check_value("rt thread", i, rt_thread[i]);
        finish_patch();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/dispatch_pkg.sv
hdl/thread_fifo.sv
hdl/switch_arbiter.sv
hdl/ic_dispatch.sv
hdl/rt_dispatch.sv
hdl/thread_context.sv
hdl/patch_dispatcher.sv
tb/patch_dispatcher_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then scan the log for a reported failure
verilator --binary --timing --assert -Wno-fatal --top-module patch_dispatcher_tb \
    -f src.f -o patch_dispatcher_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/patch_dispatcher_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
